// ==== rtl/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// ######################################################################
// datapath widths.
// ######################################################################

`define XLEN 64 // register width.
`define ALEN 64 // virtual address width.

// ######################################################################
// data store geometry.
// ######################################################################

`define ALIGN_BITS 3  // byte offset inside one 64-bit word.
`define MEM_WORDS  256 // words backed by storage.

`endif

// ==== rtl/isa_pkg.sv ====
package isa_pkg;

    // ######################################################################
    // major opcodes, instruction bits 6:2.
    // ######################################################################

    localparam logic [4:0] OP_LOAD     = 5'b00000;
    localparam logic [4:0] OP_STORE    = 5'b01000; // bit 3 marks the store form.
    localparam logic [4:0] OP_MISC_MEM = 5'b00011; // fence and fence.i.

    // ######################################################################
    // trap causes raised by this stage.
    // ######################################################################

    localparam logic [3:0] EXC_ILLEGAL_INSTR         = 4'd2;
    localparam logic [3:0] EXC_LOAD_ADDR_MISALIGNED  = 4'd4;
    localparam logic [3:0] EXC_LOAD_ACCESS_FAULT     = 4'd5;
    localparam logic [3:0] EXC_STORE_ADDR_MISALIGNED = 4'd6;
    localparam logic [3:0] EXC_STORE_ACCESS_FAULT    = 4'd7;

    // loads and fence.
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [4:0]  opcode;
        logic [1:0]  quadrant;
    } i_fmt_t;

    // stores, immediate split around rs2/rs1.
    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [4:0] opcode;
        logic [1:0] quadrant;
    } s_fmt_t;

    // one 32-bit word, two views.
    typedef union packed {
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

endpackage

// ==== rtl/mem_pkg.sv ====
`include "mem_consts.svh"

package mem_pkg;

    // access width, straight from funct3[1:0].
    typedef enum logic [1:0] {
        SIZE_BYTE  = 2'b00,
        SIZE_HALF  = 2'b01,
        SIZE_WORD  = 2'b10,
        SIZE_DWORD = 2'b11
    } access_size_e;

    // address with the byte offset stripped.
    typedef logic [`ALEN-`ALIGN_BITS-1:0] word_idx_t;

endpackage

// ==== rtl/mem_addr_gen.sv ====
`include "mem_consts.svh"

module mem_addr_gen (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    in_valid,
    input  isa_pkg::instr_u         instr,
    input  logic [`XLEN-1:0]        rs1_data,
    input  logic [`XLEN-1:0]        rs2_data,

    output logic                    ram_en,
    output logic                    ram_we,
    output mem_pkg::word_idx_t      ram_addr,
    output logic [`XLEN-1:0]        ram_wdata,
    output logic [7:0]              ram_wmask,

    output logic                    op_valid,
    output logic                    op_is_access,
    output logic                    op_is_store,
    output logic [`ALIGN_BITS-1:0]  op_offset,
    output mem_pkg::access_size_e   op_size,
    output logic                    op_unsigned,
    output logic                    op_exception,
    output logic [3:0]              op_cause,
    output logic [`ALEN-1:0]        op_addr
);
    import isa_pkg::*;
    import mem_pkg::*;

    logic [4:0]             opcode;
    logic                   store_bit;
    logic [2:0]             funct3;
    logic [11:0]            imm;
    logic [`ALEN-1:0]       addr;
    logic [`ALIGN_BITS-1:0] offset;
    access_size_e           size;
    logic                   is_load;
    logic                   is_store;
    logic                   is_misc_mem;
    logic                   is_load_store;
    logic                   misaligned;
    logic [`XLEN-1:0]       store_data;
    logic [7:0]             store_mask;
    logic                   exc;
    logic [3:0]             cause;

    // ######################################################################
    // decode and address.
    // ######################################################################

    assign opcode    = instr.i_fmt.opcode;
    assign funct3    = instr.i_fmt.funct3; // same bits in both views.
    assign store_bit = opcode[3];

    assign is_load       = opcode == OP_LOAD;
    assign is_store      = opcode == OP_STORE;
    assign is_misc_mem   = opcode == OP_MISC_MEM;
    assign is_load_store = is_load || is_store;

    assign imm = store_bit ? {instr.s_fmt.imm_hi, instr.s_fmt.imm_lo} : instr.i_fmt.imm;
    assign addr   = rs1_data + {{(`ALEN-12){imm[11]}}, imm};
    assign offset = addr[`ALIGN_BITS-1:0];
    assign size   = access_size_e'(funct3[1:0]);

    // any access not on its natural boundary is rejected.
    always_comb begin
        unique case (size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = offset[0];
            SIZE_WORD: misaligned = |offset[1:0];
            default:   misaligned = |offset;
        endcase
    end

    // ######################################################################
    // store lanes and byte mask.
    // ######################################################################

    always_comb begin
        unique case (size)
            SIZE_BYTE: begin
                store_data = {(`XLEN/8){rs2_data[7:0]}};
                store_mask = 8'b0000_0001 << offset;
            end
            SIZE_HALF: begin
                store_data = {(`XLEN/16){rs2_data[15:0]}};
                store_mask = 8'b0000_0011 << {offset[2:1], 1'b0};
            end
            SIZE_WORD: begin
                store_data = {(`XLEN/32){rs2_data[31:0]}};
                store_mask = 8'b0000_1111 << {offset[2], 2'b00};
            end
            default: begin
                store_data = rs2_data;
                store_mask = 8'hff;
            end
        endcase
    end

    assign ram_en    = in_valid && is_load_store && !misaligned;
    assign ram_we    = ram_en && is_store;
    assign ram_addr  = addr[`ALEN-1:`ALIGN_BITS];
    assign ram_wdata = store_data;
    assign ram_wmask = store_mask;

    // ######################################################################
    // exception classification and side-band.
    // ######################################################################

    always_comb begin
        exc   = 1'b0;
        cause = EXC_ILLEGAL_INSTR;
        if (is_load_store) begin
            exc   = misaligned;
            cause = is_store ? EXC_STORE_ADDR_MISALIGNED : EXC_LOAD_ADDR_MISALIGNED;
        end else if (is_misc_mem) begin
            exc = funct3 != 3'b000; // only plain fence is a no-op.
        end else begin
            exc = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid     <= 1'b0;
            op_is_access <= 1'b0;
        end else begin
            op_valid     <= in_valid;
            op_is_access <= ram_en; // a ram answer is due next cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_is_store  <= is_store;
            op_offset    <= offset;
            op_size      <= size;
            op_unsigned  <= funct3[2];
            op_exception <= exc;
            op_cause     <= cause;
            op_addr      <= addr;
        end
    end

    // offset bits below the access size are clear.
    en_not_misaligned: assert property (@(posedge clk) disable iff (rst)
        ram_en |-> (offset & ((1 << size) - 1)) == 0);

    // one mask bit per byte, starting at the offset.
    we_has_mask: assert property (@(posedge clk) disable iff (rst)
        ram_we |-> $countones(ram_wmask) == (1 << size) && ram_wmask[offset]);

endmodule

// ==== rtl/data_ram.sv ====
`include "mem_consts.svh"

module data_ram (
    input  logic               clk,
    input  logic               rst,
    input  logic               ram_en,
    input  logic               ram_we,
    input  mem_pkg::word_idx_t ram_addr,
    input  logic [`XLEN-1:0]   ram_wdata,
    input  logic [7:0]         ram_wmask,
    output logic [`XLEN-1:0]   ram_rdata,
    output logic               ram_fault
);
    localparam int IDX_BITS = $clog2(`MEM_WORDS);

    logic [`XLEN-1:0]    mem [`MEM_WORDS];
    logic                in_range;
    logic [IDX_BITS-1:0] idx;

    assign in_range = ram_addr < `MEM_WORDS;
    assign idx      = ram_addr[IDX_BITS-1:0];

    // ######################################################################
    // storage port.
    // ######################################################################

    always_ff @(posedge clk) begin
        if (ram_en && in_range) begin
            ram_rdata <= mem[idx]; // old word on read-during-write.
            if (ram_we) begin
                for (int b = 0; b < `XLEN/8; b++) begin
                    if (ram_wmask[b]) begin
                        mem[idx][b*8 +: 8] <= ram_wdata[b*8 +: 8];
                    end
                end
            end
        end
    end

    // out-of-range index, no access.
    always_ff @(posedge clk) begin
        if (rst) begin
            ram_fault <= 1'b0;
        end else begin
            ram_fault <= ram_en && !in_range;
        end
    end

    // a faulting access leaves the read word alone.
    fault_after_en: assert property (@(posedge clk) disable iff (rst)
        ram_fault |-> $past(ram_en) && $stable(ram_rdata));

endmodule

// ==== rtl/load_result.sv ====
`include "mem_consts.svh"

module load_result (
    input  logic                   op_valid,
    input  logic                   op_is_access,
    input  logic                   op_is_store,
    input  logic [`ALIGN_BITS-1:0] op_offset,
    input  mem_pkg::access_size_e  op_size,
    input  logic                   op_unsigned,
    input  logic                   op_exception,
    input  logic [3:0]             op_cause,
    input  logic [`ALEN-1:0]       op_addr,
    input  logic [`XLEN-1:0]       ram_rdata,
    input  logic                   ram_fault,

    output logic                   out_valid,
    output logic                   exception,
    output logic [3:0]             trap_cause,
    output logic [`ALEN-1:0]       fault_addr,
    output logic [`XLEN-1:0]       result
);
    import isa_pkg::*;
    import mem_pkg::*;

    logic [7:0]       lane_byte;
    logic [15:0]      lane_half;
    logic [31:0]      lane_word;
    logic [`XLEN-1:0] loaded;

    // ######################################################################
    // lane extraction and extension.
    // ######################################################################

    assign lane_byte = ram_rdata[{op_offset, 3'b000} +: 8];
    assign lane_half = ram_rdata[{op_offset[2:1], 4'b0000} +: 16];
    assign lane_word = ram_rdata[{op_offset[2], 5'b00000} +: 32];

    always_comb begin
        unique case (op_size)
            SIZE_BYTE: begin
                loaded = op_unsigned ? {{(`XLEN-8){1'b0}}, lane_byte}
                                     : {{(`XLEN-8){lane_byte[7]}}, lane_byte};
            end
            SIZE_HALF: begin
                loaded = op_unsigned ? {{(`XLEN-16){1'b0}}, lane_half}
                                     : {{(`XLEN-16){lane_half[15]}}, lane_half};
            end
            SIZE_WORD: begin
                loaded = op_unsigned ? {{(`XLEN-32){1'b0}}, lane_word}
                                     : {{(`XLEN-32){lane_word[31]}}, lane_word};
            end
            default: loaded = ram_rdata; // whole dword.
        endcase
    end

    // ######################################################################
    // result and trap selection.
    // ######################################################################

    assign out_valid  = op_valid;
    assign fault_addr = op_addr;

    always_comb begin
        exception  = 1'b0;
        trap_cause = op_cause;
        result     = '0;
        if (op_valid) begin
            if (op_is_access && ram_fault) begin
                // range fault from the store.
                exception  = 1'b1;
                trap_cause = op_is_store ? EXC_STORE_ACCESS_FAULT : EXC_LOAD_ACCESS_FAULT;
            end else if (op_exception) begin
                exception = 1'b1;
            end else if (op_is_access && !op_is_store) begin
                result = loaded;
            end
        end
    end

    // an access that reached the ram carries no early exception.
    access_not_excepted: assert final (op_valid !== 1'b1 || !(op_is_access && op_exception));

endmodule

// ==== rtl/mem_stage.sv ====
`include "mem_consts.svh"

module mem_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  isa_pkg::instr_u  instr,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    output logic             out_valid,
    output logic             exception,
    output logic [3:0]       trap_cause,
    output logic [`ALEN-1:0] fault_addr,
    output logic [`XLEN-1:0] result
);
    import mem_pkg::*;

    // issue-cycle ram port.
    logic                   ram_en;
    logic                   ram_we;
    word_idx_t              ram_addr;
    logic [`XLEN-1:0]       ram_wdata;
    logic [7:0]             ram_wmask;

    // answer one cycle later.
    logic [`XLEN-1:0]       ram_rdata;
    logic                   ram_fault;

    // registered side-band.
    logic                   op_valid;
    logic                   op_is_access;
    logic                   op_is_store;
    logic [`ALIGN_BITS-1:0] op_offset;
    access_size_e           op_size;
    logic                   op_unsigned;
    logic                   op_exception;
    logic [3:0]             op_cause;
    logic [`ALEN-1:0]       op_addr;

    mem_addr_gen mem_addr_gen_i (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .instr        (instr),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .ram_en       (ram_en),
        .ram_we       (ram_we),
        .ram_addr     (ram_addr),
        .ram_wdata    (ram_wdata),
        .ram_wmask    (ram_wmask),
        .op_valid     (op_valid),
        .op_is_access (op_is_access),
        .op_is_store  (op_is_store),
        .op_offset    (op_offset),
        .op_size      (op_size),
        .op_unsigned  (op_unsigned),
        .op_exception (op_exception),
        .op_cause     (op_cause),
        .op_addr      (op_addr)
    );

    data_ram data_ram_i (
        .clk       (clk),
        .rst       (rst),
        .ram_en    (ram_en),
        .ram_we    (ram_we),
        .ram_addr  (ram_addr),
        .ram_wdata (ram_wdata),
        .ram_wmask (ram_wmask),
        .ram_rdata (ram_rdata),
        .ram_fault (ram_fault)
    );

    load_result load_result_i (
        .op_valid     (op_valid),
        .op_is_access (op_is_access),
        .op_is_store  (op_is_store),
        .op_offset    (op_offset),
        .op_size      (op_size),
        .op_unsigned  (op_unsigned),
        .op_exception (op_exception),
        .op_cause     (op_cause),
        .op_addr      (op_addr),
        .ram_rdata    (ram_rdata),
        .ram_fault    (ram_fault),
        .out_valid    (out_valid),
        .exception    (exception),
        .trap_cause   (trap_cause),
        .fault_addr   (fault_addr),
        .result       (result)
    );

endmodule

// ==== tests/mem_stage_tb.sv ====
`include "mem_consts.svh"

module mem_stage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import isa_pkg::*;

    localparam int LIMIT      = 16; // cycles before a wait gives up.
    localparam int USED_WORDS = 16; // words filled before any load.

    logic             clk;
    logic             rst;
    logic             in_valid;
    instr_u           instr;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic             out_valid;
    logic             exception;
    logic [3:0]       trap_cause;
    logic [`ALEN-1:0] fault_addr;
    logic [`XLEN-1:0] result;

    logic [`XLEN-1:0] shadow [`MEM_WORDS]; // reference copy of the data store.

    // expectation for the word on the inputs.
    logic             pend_valid;
    logic             pend_exc;
    logic [3:0]       pend_cause;
    logic             pend_chk_addr;
    logic [`ALEN-1:0] pend_addr;
    logic [`XLEN-1:0] pend_result;

    // lined up with out_valid.
    logic             exp_valid;
    logic             exp_exc;
    logic [3:0]       exp_cause;
    logic             exp_chk_addr;
    logic [`ALEN-1:0] exp_addr;
    logic [`XLEN-1:0] exp_result;

    mem_stage mem_stage_i (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .instr      (instr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .out_valid  (out_valid),
        .exception  (exception),
        .trap_cause (trap_cause),
        .fault_addr (fault_addr),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        exp_valid    <= pend_valid;
        exp_exc      <= pend_exc;
        exp_cause    <= pend_cause;
        exp_chk_addr <= pend_chk_addr;
        exp_addr     <= pend_addr;
        exp_result   <= pend_result;
    end

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Test failures found");
        $fatal(1, "simulation stopped");
    endtask

    // ######################################################################
    // output checks, one cycle after each issue.
    // ######################################################################

    valid_ok: assert property (@(posedge clk) disable iff (rst) out_valid === exp_valid)
        else stop_run($sformatf("** Error at %0t: out_valid %b, expected %b",
                                $time, $sampled(out_valid), $sampled(exp_valid)));

    exception_ok: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> exception === exp_exc)
        else stop_run($sformatf("** Error at %0t: exception %b, expected %b",
                                $time, $sampled(exception), $sampled(exp_exc)));

    cause_ok: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_exc |-> trap_cause === exp_cause)
        else stop_run($sformatf("** Error at %0t: trap_cause %0d, expected %0d",
                                $time, $sampled(trap_cause), $sampled(exp_cause)));

    addr_ok: assert property (@(posedge clk) disable iff (rst)
        exp_valid && exp_chk_addr |-> fault_addr === exp_addr)
        else stop_run($sformatf("** Error at %0t: fault_addr %h, expected %h",
                                $time, $sampled(fault_addr), $sampled(exp_addr)));

    result_ok: assert property (@(posedge clk) disable iff (rst)
        exp_valid |-> result === exp_result)
        else stop_run($sformatf("** Error at %0t: result %h, expected %h",
                                $time, $sampled(result), $sampled(exp_result)));

    // ######################################################################
    // stimulus helpers.
    // ######################################################################

    function automatic logic [`ALEN-1:0] sext12(input logic [11:0] imm);
        logic signed [`ALEN-1:0] v;
        v = signed'(imm);
        return v;
    endfunction

    // aligned address inside the filled words.
    function automatic logic [`ALEN-1:0] aligned_addr(input int nbytes);
        int word;
        int off;
        word = $urandom_range(0, USED_WORDS - 1);
        off  = $urandom_range(0, 7) & ~(nbytes - 1);
        return word * 8 + off;
    endfunction

    task automatic issue(input instr_u word, input logic [`XLEN-1:0] a,
                         input logic [`XLEN-1:0] b, input logic e, input logic [3:0] c,
                         input logic [`ALEN-1:0] fa, input logic [`XLEN-1:0] res);
        @(posedge clk);
        in_valid      <= 1'b1;
        instr         <= word;
        rs1_data      <= a;
        rs2_data      <= b;
        pend_valid    <= 1'b1;
        pend_exc      <= e;
        pend_cause    <= c;
        pend_chk_addr <= e && (c != EXC_ILLEGAL_INSTR);
        pend_addr     <= fa;
        pend_result   <= res;
    endtask

    task automatic do_load(input logic [2:0] funct3, input logic [`ALEN-1:0] addr);
        instr_u           word;
        logic [11:0]      imm;
        int               nbytes;
        logic [`ALEN-1:0] idx;
        logic [`XLEN-1:0] val;
        logic             e;
        logic [3:0]       c;
        imm    = 12'($urandom);
        nbytes = 1 << funct3[1:0];
        idx    = addr >> `ALIGN_BITS;
        word   = '0;
        word.i_fmt.imm      = imm;
        word.i_fmt.rs1      = 5'd1;
        word.i_fmt.funct3   = funct3;
        word.i_fmt.rd       = 5'd10;
        word.i_fmt.opcode   = OP_LOAD;
        word.i_fmt.quadrant = 2'b11;
        val = '0;
        e   = 1'b0;
        c   = 4'd0;
        if (addr % nbytes != 0) begin
            e = 1'b1;
            c = EXC_LOAD_ADDR_MISALIGNED;
        end else if (idx >= `MEM_WORDS) begin
            e = 1'b1;
            c = EXC_LOAD_ACCESS_FAULT;
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                val[i*8 +: 8] = shadow[idx][(addr[2:0] + i)*8 +: 8];
            end
            if (!funct3[2] && nbytes < 8 && val[nbytes*8-1]) begin
                for (int i = nbytes; i < 8; i++) begin
                    val[i*8 +: 8] = 8'hff; // sign fill.
                end
            end
        end
        issue(word, addr - sext12(imm), {$urandom, $urandom}, e, c, addr, val);
    endtask

    task automatic do_store(input logic [1:0] size, input logic [`ALEN-1:0] addr,
                            input logic [`XLEN-1:0] data);
        instr_u           word;
        logic [11:0]      imm;
        int               nbytes;
        logic [`ALEN-1:0] idx;
        logic             e;
        logic [3:0]       c;
        imm    = 12'($urandom);
        nbytes = 1 << size;
        idx    = addr >> `ALIGN_BITS;
        word   = '0;
        word.s_fmt.imm_hi   = imm[11:5];
        word.s_fmt.rs2      = 5'd11;
        word.s_fmt.rs1      = 5'd1;
        word.s_fmt.funct3   = {1'b0, size};
        word.s_fmt.imm_lo   = imm[4:0];
        word.s_fmt.opcode   = OP_STORE;
        word.s_fmt.quadrant = 2'b11;
        e = 1'b0;
        c = 4'd0;
        if (addr % nbytes != 0) begin
            e = 1'b1;
            c = EXC_STORE_ADDR_MISALIGNED;
        end else if (idx >= `MEM_WORDS) begin
            e = 1'b1;
            c = EXC_STORE_ACCESS_FAULT;
        end else begin
            for (int i = 0; i < nbytes; i++) begin
                shadow[idx][(addr[2:0] + i)*8 +: 8] = data[i*8 +: 8];
            end
        end
        issue(word, addr - sext12(imm), data, e, c, addr, '0);
    endtask

    task automatic do_misc(input logic [4:0] opcode, input logic [2:0] funct3,
                           input logic e);
        instr_u word;
        word = '0;
        word.i_fmt.funct3   = funct3;
        word.i_fmt.opcode   = opcode;
        word.i_fmt.quadrant = 2'b11;
        issue(word, {$urandom, $urandom}, '0, e, EXC_ILLEGAL_INSTR, '0, '0);
    endtask

    // idle the inputs, then see the last answer come and go.
    task automatic drain();
        int n;
        @(posedge clk);
        in_valid   <= 1'b0;
        pend_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > LIMIT) stop_run("timeout: out_valid did not rise after the last issue");
        end while (out_valid !== 1'b1);
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > LIMIT) stop_run("timeout: out_valid did not fall after the last issue");
        end while (out_valid !== 1'b0);
    endtask

    // ######################################################################
    // test sequence.
    // ######################################################################

    initial begin
        logic [1:0] size;
        void'($urandom(32'hcd75311f));
        rst           = 1'b1;
        in_valid      = 1'b0;
        instr         = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        pend_valid    = 1'b0;
        pend_exc      = 1'b0;
        pend_cause    = '0;
        pend_chk_addr = 1'b0;
        pend_addr     = '0;
        pend_result   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int w = 0; w < USED_WORDS; w++) begin
            do_store(2'd3, w * 8, {$urandom, $urandom}); // back to back fill.
        end
        drain();

        // random stores, then every load kind.
        for (int k = 0; k < 40; k++) begin
            size = 2'($urandom_range(0, 3));
            do_store(size, aligned_addr(1 << size), {$urandom, $urandom});
            for (int f = 0; f < 7; f++) begin
                do_load(3'(f), aligned_addr(1 << f[1:0]));
            end
            if ($urandom_range(0, 3) == 0) drain();
        end

        // misaligned half, word, dword.
        for (int s = 1; s < 4; s++) begin
            do_load(3'(s), 64'd24 + (1 << (s - 1)));
            do_store(2'(s), 64'd40 + (1 << (s - 1)), {$urandom, $urandom});
            drain();
            do_load(3'd3, 64'd40);
            drain();
        end

        // past the end of the store.
        for (int w = 0; w < 3; w++) begin
            do_load(3'd3, (`MEM_WORDS + w) * 8);
            do_store(2'd3, (`MEM_WORDS + w) * 8, {$urandom, $urandom});
            do_load(3'd3, w * 8); // wrapped index stays untouched.
        end
        do_store(2'd2, 64'hffff_ffff_ffff_fff0, {$urandom, $urandom});
        drain();

        do_misc(OP_MISC_MEM, 3'b000, 1'b0);
        do_misc(OP_MISC_MEM, 3'b001, 1'b1); // fence.i.
        do_misc(5'b00100, 3'b000, 1'b1);
        drain();

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/isa_pkg.sv
rtl/mem_pkg.sv
rtl/mem_addr_gen.sv
rtl/data_ram.sv
rtl/load_result.sv
rtl/mem_stage.sv
tests/mem_stage_tb.sv

// ==== Bender.yml ====
package:
  name: mem_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/mem_pkg.sv
      - rtl/mem_addr_gen.sv
      - rtl/data_ram.sv
      - rtl/load_result.sv
      - rtl/mem_stage.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - tests/mem_stage_tb.sv
